// File: icache_pkg.sv
//--------------------------------------------------------------------------
// Instruction cache shared definitions
// Address split, cache geometry, AXI read channel structs, FSM encoding
//--------------------------------------------------------------------------
package icache_pkg;

  // Address split
  localparam int ADDR_W      = 32;
  localparam int LINE_OFFS_W = 5;
  localparam int SET_W       = 8;
  localparam int NUM_SETS    = 1 << SET_W;
  // Upper bits 31..13 compared against the stored tag
  localparam int TAG_W       = ADDR_W - SET_W - LINE_OFFS_W;

  // Fetch word geometry
  localparam int FETCH_W     = 64;
  localparam int WORD_OFFS_W = $clog2(FETCH_W / 8);
  // Set index plus 64-bit word within the line
  localparam int DATA_IDX_W  = SET_W + LINE_OFFS_W - WORD_OFFS_W;

  // Bus geometry
  localparam int         AXI_DATA_W     = 32;
  localparam int         BEATS_PER_LINE = 8;
  localparam logic [7:0] ARLEN_LINE     = 8'(BEATS_PER_LINE - 1);
  localparam logic [1:0] BURST_INCR     = 2'd1;

  typedef logic [SET_W-1:0]      set_idx_t;
  typedef logic [DATA_IDX_W-1:0] data_idx_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [FETCH_W-1:0]    fetch_t;

  // Tag RAM entry
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // AXI read address channel
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        id;
    logic [7:0]        len;
    logic [1:0]        burst;
  } axi_ar_t;

  // AXI read data channel
  typedef struct packed {
    logic                  valid;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  typedef enum logic [1:0] {
    FLUSH    = 2'd0,
    LOOKUP   = 2'd1,
    REFILL   = 2'd2,
    RELOOKUP = 2'd3
  } cache_state_e;

endpackage

// File: icache_ram.sv
//--------------------------------------------------------------------------
// Single-port synchronous RAM
// Registered read, entry type and depth set by parameters
//--------------------------------------------------------------------------
module icache_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 256
) (
  input  logic                     clk_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entry_t                   data_i,
  input  logic                     wr_i,
  output entry_t                   data_o
);

  // Storage array
  entry_t mem_q [DEPTH];

  // Write port
  always_ff @(posedge clk_i)
  begin
    if (wr_i)
      mem_q[addr_i] <= data_i;
  end

  // Read returns the old contents on a write to the same entry
  always_ff @(posedge clk_i)
  begin
    data_o <= mem_q[addr_i];
  end

endmodule

// File: icache_way.sv
//--------------------------------------------------------------------------
// Instruction cache way
// Tag RAM, data RAM and the tag compare for one way
//--------------------------------------------------------------------------
module icache_way (
  input  logic                   clk_i,
  // Tag port
  input  icache_pkg::set_idx_t   tag_addr_i,
  input  logic                   tag_wr_i,
  input  icache_pkg::tag_entry_t tag_data_i,
  // Data port
  input  icache_pkg::data_idx_t  data_addr_i,
  input  logic                   data_wr_i,
  input  icache_pkg::fetch_t     data_i,
  // Lookup
  input  icache_pkg::tag_t       cmp_tag_i,
  output logic                   hit_o,
  output icache_pkg::fetch_t     data_o
);

  import icache_pkg::*;

  tag_entry_t tag_q;

  //------------------------------------------------------------------------
  // Tag storage, one entry per set
  //------------------------------------------------------------------------
  icache_ram #(
    .entry_t (tag_entry_t),
    .DEPTH   (NUM_SETS)
  ) u_tag_ram (
    .clk_i  (clk_i),
    .addr_i (tag_addr_i),
    .data_i (tag_data_i),
    .wr_i   (tag_wr_i),
    .data_o (tag_q)
  );

  //------------------------------------------------------------------------
  // Data storage, four fetch words per line
  //------------------------------------------------------------------------
  icache_ram #(
    .entry_t (fetch_t),
    .DEPTH   (1 << DATA_IDX_W)
  ) u_data_ram (
    .clk_i  (clk_i),
    .addr_i (data_addr_i),
    .data_i (data_i),
    .wr_i   (data_wr_i),
    .data_o (data_o)
  );

  // Hit on a valid entry with matching tag
  assign hit_o = tag_q.valid && (tag_q.tag == cmp_tag_i);

endmodule

// File: icache_refill.sv
//--------------------------------------------------------------------------
// Instruction cache refill engine
// Issues the AXI line burst, pairs 32-bit beats into fetch words,
// tracks the refill write index and the sticky read error
//--------------------------------------------------------------------------
module icache_refill #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // From controller
  input  logic                          miss_start_i,
  input  logic [icache_pkg::ADDR_W-1:0] line_addr_i,
  input  logic                          hit_valid_i,
  // AXI read channels
  output icache_pkg::axi_ar_t           ar_o,
  input  logic                          arready_i,
  input  icache_pkg::axi_r_t            r_i,
  output logic                          rready_o,
  // To controller
  output logic                          beat_wr_o,
  output icache_pkg::fetch_t            beat_data_o,
  output icache_pkg::data_idx_t         beat_idx_o,
  output logic                          line_done_o,
  output logic                          error_o
);

  import icache_pkg::*;

  localparam int BEAT_CNT_W = $clog2(BEATS_PER_LINE);

  logic                  arvalid_q;
  logic                  burst_busy_q;
  logic [BEAT_CNT_W-1:0] beat_cnt_q;
  logic [AXI_DATA_W-1:0] lower_q;
  data_idx_t             beat_idx_q;

  // Always ready, no back-pressure on R
  assign rready_o    = 1'b1;
  assign line_done_o = r_i.valid && r_i.last;

  //------------------------------------------------------------------------
  // Read address, held until accepted
  //------------------------------------------------------------------------
  assign ar_o = '{valid: miss_start_i || arvalid_q,
                  addr:  line_addr_i,
                  id:    AXI_ID,
                  len:   ARLEN_LINE,
                  burst: BURST_INCR};

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      arvalid_q    <= 1'b0;
      burst_busy_q <= 1'b0;
      beat_cnt_q   <= '0;
      error_o      <= 1'b0;
    end
    else
    begin
      arvalid_q <= ar_o.valid && !arready_i;
      // Burst in flight from the miss until the last beat
      if (miss_start_i)
        burst_busy_q <= 1'b1;
      else if (line_done_o)
        burst_busy_q <= 1'b0;
      // Beat position within the line
      if (line_done_o)
        beat_cnt_q <= '0;
      else if (r_i.valid)
        beat_cnt_q <= beat_cnt_q + 1'b1;
      // Sticky until the next returned fetch
      if (r_i.valid && rready_o && (r_i.resp != 2'b00))
        error_o <= 1'b1;
      else if (hit_valid_i)
        error_o <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // Beat pairing
  //------------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (r_i.valid)
      lower_q <= r_i.data;
    // First word of the line, then step after each pair
    if (miss_start_i)
      beat_idx_q <= line_addr_i[WORD_OFFS_W +: DATA_IDX_W];
    else if (beat_wr_o)
      beat_idx_q <= beat_idx_q + 1'b1;
  end

  // Odd beat completes a fetch word
  assign beat_wr_o   = r_i.valid && beat_cnt_q[0];
  assign beat_data_o = {r_i.data, lower_q};
  assign beat_idx_o  = beat_idx_q;

  // One burst at a time
  a_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
    miss_start_i |-> !burst_busy_q);

  // Eighth beat must close the burst
  a_beat_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    (r_i.valid && (beat_cnt_q == BEAT_CNT_W'(BEATS_PER_LINE - 1))) |-> r_i.last);

endmodule

// File: icache_ctrl.sv
//--------------------------------------------------------------------------
// Instruction cache controller
// FSM, lookup registers, flush and invalidate, replacement way and the
// tag/data RAM addressing for both ways
//--------------------------------------------------------------------------
module icache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Fetch requests
  input  logic                          req_rd_i,
  input  logic                          req_flush_i,
  input  logic                          req_invalidate_i,
  input  logic [icache_pkg::ADDR_W-1:0] req_pc_i,
  output logic                          req_accept_o,
  output logic                          req_valid_o,
  output icache_pkg::fetch_t            req_inst_o,
  // Way results
  input  logic [1:0]                    hit_i,
  input  icache_pkg::fetch_t [1:0]      way_data_i,
  // Way RAM control
  output icache_pkg::set_idx_t          tag_addr_o,
  output icache_pkg::tag_entry_t        tag_data_o,
  output logic [1:0]                    tag_wr_o,
  output icache_pkg::data_idx_t         data_addr_o,
  output logic [1:0]                    data_wr_o,
  output icache_pkg::fetch_t            data_o,
  output icache_pkg::tag_t              cmp_tag_o,
  // Refill engine
  output logic                          miss_start_o,
  output logic [icache_pkg::ADDR_W-1:0] line_addr_o,
  input  logic                          beat_wr_i,
  input  icache_pkg::fetch_t            beat_data_i,
  input  icache_pkg::data_idx_t         beat_idx_i,
  input  logic                          line_done_i
);

  import icache_pkg::*;

  cache_state_e      state_q;
  cache_state_e      state_d;
  logic              lookup_valid_q;
  logic [ADDR_W-1:0] lookup_addr_q;
  set_idx_t          flush_addr_q;
  logic              invalidate_q;
  logic              replace_way_q;
  logic              hit_any;

  assign hit_any      = |hit_i;
  // Looked up last cycle and neither way matched
  assign miss_start_o = (state_q == LOOKUP) && lookup_valid_q && !hit_any;
  assign req_accept_o = (state_q == LOOKUP) && !miss_start_o;
  assign req_valid_o  = (state_q == LOOKUP) && lookup_valid_q && hit_any;
  assign req_inst_o   = hit_i[1] ? way_data_i[1] : way_data_i[0];

  //------------------------------------------------------------------------
  // FSM
  //------------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FLUSH:
        if (invalidate_q || (flush_addr_q == set_idx_t'(NUM_SETS - 1)))
          state_d = LOOKUP;
      LOOKUP:
        if (miss_start_o)
          state_d = REFILL;
        else if (req_flush_i || req_invalidate_i)
          state_d = FLUSH;
      REFILL:
        if (line_done_i)
          state_d = RELOOKUP;
      RELOOKUP:
        state_d = LOOKUP;
      default:
        state_d = FLUSH;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q        <= FLUSH;
      lookup_valid_q <= 1'b0;
      flush_addr_q   <= '0;
      invalidate_q   <= 1'b0;
      replace_way_q  <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      invalidate_q <= req_invalidate_i && req_accept_o;
      // Pending read until its word is returned
      if (req_rd_i && req_accept_o)
        lookup_valid_q <= 1'b1;
      else if (req_valid_o)
        lookup_valid_q <= 1'b0;
      // Sweep all sets, or clear only the invalidated one
      if (state_q == FLUSH)
        flush_addr_q <= flush_addr_q + 1'b1;
      else if (req_invalidate_i && req_accept_o)
        flush_addr_q <= req_pc_i[LINE_OFFS_W +: SET_W];
      else
        flush_addr_q <= '0;
      // Alternate victim way after every refill
      if (line_done_i)
        replace_way_q <= !replace_way_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_rd_i && req_accept_o)
      lookup_addr_q <= req_pc_i;
  end

  //------------------------------------------------------------------------
  // RAM addressing
  //------------------------------------------------------------------------
  assign cmp_tag_o   = lookup_addr_q[ADDR_W-1 -: TAG_W];
  assign line_addr_o = {lookup_addr_q[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};

  always_comb
  begin
    case (state_q)
      FLUSH:    tag_addr_o = flush_addr_q;
      REFILL,
      RELOOKUP: tag_addr_o = lookup_addr_q[LINE_OFFS_W +: SET_W];
      default:  tag_addr_o = req_pc_i[LINE_OFFS_W +: SET_W];
    endcase
    case (state_q)
      REFILL:   data_addr_o = beat_idx_i;
      RELOOKUP: data_addr_o = lookup_addr_q[WORD_OFFS_W +: DATA_IDX_W];
      default:  data_addr_o = req_pc_i[WORD_OFFS_W +: DATA_IDX_W];
    endcase
  end

  // Flush writes zero, refill marks the new line valid
  assign tag_data_o = (state_q == REFILL) ? '{valid: 1'b1, tag: cmp_tag_o} : '0;
  assign tag_wr_o[0] = (state_q == FLUSH) || ((state_q == REFILL) && line_done_i && !replace_way_q);
  assign tag_wr_o[1] = (state_q == FLUSH) || ((state_q == REFILL) && line_done_i && replace_way_q);

  assign data_o       = beat_data_i;
  assign data_wr_o[0] = (state_q == REFILL) && beat_wr_i && !replace_way_q;
  assign data_wr_o[1] = (state_q == REFILL) && beat_wr_i && replace_way_q;

  // A line lives in at most one way
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    ((state_q == LOOKUP) && lookup_valid_q) |-> !(hit_i[0] && hit_i[1]));

endmodule

// File: icache_top.sv
//--------------------------------------------------------------------------
// Two-way 16 KB instruction cache with AXI line refill
//--------------------------------------------------------------------------
module icache_top #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Fetch side
  input  logic                          req_rd_i,
  input  logic                          req_flush_i,
  input  logic                          req_invalidate_i,
  input  logic [icache_pkg::ADDR_W-1:0] req_pc_i,
  output logic                          req_accept_o,
  output logic                          req_valid_o,
  output logic                          req_error_o,
  output icache_pkg::fetch_t            req_inst_o,
  // AXI read side
  output icache_pkg::axi_ar_t           ar_o,
  input  logic                          arready_i,
  input  icache_pkg::axi_r_t            r_i,
  output logic                          rready_o
);

  import icache_pkg::*;

  // Way RAM control
  set_idx_t         tag_addr;
  tag_entry_t       tag_data;
  logic [1:0]       tag_wr;
  data_idx_t        data_addr;
  logic [1:0]       data_wr;
  fetch_t           data_wr_word;
  tag_t             cmp_tag;
  logic [1:0]       hit;
  fetch_t [1:0]     way_data;
  // Refill link
  logic              miss_start;
  logic [ADDR_W-1:0] line_addr;
  logic              beat_wr;
  fetch_t            beat_data;
  data_idx_t         beat_idx;
  logic              line_done;

  icache_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_rd_i         (req_rd_i),
    .req_flush_i      (req_flush_i),
    .req_invalidate_i (req_invalidate_i),
    .req_pc_i         (req_pc_i),
    .req_accept_o     (req_accept_o),
    .req_valid_o      (req_valid_o),
    .req_inst_o       (req_inst_o),
    .hit_i            (hit),
    .way_data_i       (way_data),
    .tag_addr_o       (tag_addr),
    .tag_data_o       (tag_data),
    .tag_wr_o         (tag_wr),
    .data_addr_o      (data_addr),
    .data_wr_o        (data_wr),
    .data_o           (data_wr_word),
    .cmp_tag_o        (cmp_tag),
    .miss_start_o     (miss_start),
    .line_addr_o      (line_addr),
    .beat_wr_i        (beat_wr),
    .beat_data_i      (beat_data),
    .beat_idx_i       (beat_idx),
    .line_done_i      (line_done)
  );

  icache_refill #(
    .AXI_ID (AXI_ID)
  ) u_refill (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .miss_start_i (miss_start),
    .line_addr_i  (line_addr),
    .hit_valid_i  (req_valid_o),
    .ar_o         (ar_o),
    .arready_i    (arready_i),
    .r_i          (r_i),
    .rready_o     (rready_o),
    .beat_wr_o    (beat_wr),
    .beat_data_o  (beat_data),
    .beat_idx_o   (beat_idx),
    .line_done_o  (line_done),
    .error_o      (req_error_o)
  );

  icache_way u_way0 (
    .clk_i       (clk_i),
    .tag_addr_i  (tag_addr),
    .tag_wr_i    (tag_wr[0]),
    .tag_data_i  (tag_data),
    .data_addr_i (data_addr),
    .data_wr_i   (data_wr[0]),
    .data_i      (data_wr_word),
    .cmp_tag_i   (cmp_tag),
    .hit_o       (hit[0]),
    .data_o      (way_data[0])
  );

  icache_way u_way1 (
    .clk_i       (clk_i),
    .tag_addr_i  (tag_addr),
    .tag_wr_i    (tag_wr[1]),
    .tag_data_i  (tag_data),
    .data_addr_i (data_addr),
    .data_wr_i   (data_wr[1]),
    .data_i      (data_wr_word),
    .cmp_tag_i   (cmp_tag),
    .hit_o       (hit[1]),
    .data_o      (way_data[1])
  );

endmodule

// File: tb_icache.sv
//--------------------------------------------------------------------------
// Instruction cache testbench
// Table-driven reads, flush and invalidate against an AXI memory model
//--------------------------------------------------------------------------
module tb_icache;

  import icache_pkg::*;

  localparam logic [3:0] AXI_ID         = 4'hA;
  localparam int         NUM_ROWS       = 24;
  localparam int         TIMEOUT_CYCLES = NUM_ROWS * 300 + 400;

  localparam logic [1:0] OP_READ  = 2'd0;
  localparam logic [1:0] OP_FLUSH = 2'd1;
  localparam logic [1:0] OP_INVAL = 2'd2;

  // One stimulus row
  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] pc;
    logic        inject_error;
    logic        expect_miss;
    logic        expect_error;
  } row_t;

  // DUT ports
  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        req_rd_i;
  logic        req_flush_i;
  logic        req_invalidate_i;
  logic [31:0] req_pc_i;
  logic        req_accept_o;
  logic        req_valid_o;
  logic        req_error_o;
  fetch_t      req_inst_o;
  axi_ar_t     ar_o;
  logic        arready_i;
  axi_r_t      r_i;
  logic        rready_o;

  // Bookkeeping
  row_t        rows [NUM_ROWS];
  int          cur_row;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          ar_count = 0;
  axi_ar_t     last_ar;
  logic        err_inject;
  logic [15:0] lfsr_q = 16'd18;

  always #2 clk_i = ~clk_i;

  icache_top #(
    .AXI_ID (AXI_ID)
  ) u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_rd_i         (req_rd_i),
    .req_flush_i      (req_flush_i),
    .req_invalidate_i (req_invalidate_i),
    .req_pc_i         (req_pc_i),
    .req_accept_o     (req_accept_o),
    .req_valid_o      (req_valid_o),
    .req_error_o      (req_error_o),
    .req_inst_o       (req_inst_o),
    .ar_o             (ar_o),
    .arready_i        (arready_i),
    .r_i              (r_i),
    .rready_o         (rready_o)
  );

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------
  // Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0])
      next = next ^ 16'hB400;
    return next;
  endfunction

  task automatic draw_bit(output logic bit_o);
    bit_o  = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // Memory contents unique per byte address
  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return byte_addr ^ 32'h5A5A_0000;
  endfunction

  // Lower address in the low half
  function automatic fetch_t expected_fetch(input logic [31:0] pc);
    logic [31:0] base;
    base = {pc[31:3], 3'b000};
    return {mem_word(base + 32'd4), mem_word(base)};
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h (row %0d)", name, got, exp, cur_row);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  //------------------------------------------------------------------------
  // AXI memory model with 8 beats per AR and random gaps
  //------------------------------------------------------------------------
  initial
  begin
    logic        take;
    logic        burst_live;
    int          beat;
    logic [31:0] burst_addr;
    arready_i  = 1'b0;
    r_i        = '0;
    burst_live = 1'b0;
    beat       = 0;
    burst_addr = '0;
    forever
    begin
      @(negedge clk_i);
      r_i       = '0;
      arready_i = 1'b0;
      if (burst_live)
      begin
        draw_bit(take);
        if (take)
        begin
          check_true(rready_o, "R beat offered while rready_o is low");
          // Third beat carries the error when injected
          r_i = '{valid: 1'b1,
                  data:  mem_word(burst_addr + 32'(beat * 4)),
                  resp:  (err_inject && (beat == 2)) ? 2'b10 : 2'b00,
                  last:  (beat == 7)};
          if (beat == 7)
            burst_live = 1'b0;
          beat++;
        end
      end
      draw_bit(take);
      arready_i = take;
      // Handshake at the coming rising edge with beats a cycle later
      if (ar_o.valid && arready_i)
      begin
        last_ar    = ar_o;
        ar_count++;
        burst_addr = ar_o.addr;
        beat       = 0;
        burst_live = 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // Request tasks entered and left at a falling edge
  //------------------------------------------------------------------------
  task automatic apply_read(input row_t row);
    int     latency;
    int     bursts_before;
    fetch_t expected;
    expected      = expected_fetch(row.pc);
    bursts_before = ar_count;
    err_inject    = row.inject_error;
    req_pc_i      = row.pc;
    req_rd_i      = 1'b1;
    while (!req_accept_o)
      @(negedge clk_i);
    @(negedge clk_i);
    req_rd_i = 1'b0;
    latency  = 1;
    while (!req_valid_o)
    begin
      @(negedge clk_i);
      latency++;
    end
    check_equal("req_inst_o", req_inst_o, expected);
    check_equal("req_error_o", 64'(req_error_o), 64'(row.expect_error));
    check_true(ar_count - bursts_before == (row.expect_miss ? 1 : 0),
               $sformatf("row %0d: %0d read bursts issued, expected %0d", cur_row,
                         ar_count - bursts_before, row.expect_miss ? 1 : 0));
    if (row.expect_miss)
    begin
      check_true(latency > 1, $sformatf("row %0d: miss answered after one cycle", cur_row));
      check_equal("ar_o.addr", 64'(last_ar.addr), 64'({row.pc[31:5], 5'b00000}));
      check_equal("ar_o.len", 64'(last_ar.len), 64'(8'd7));
      check_equal("ar_o.burst", 64'(last_ar.burst), 64'(2'd1));
      check_equal("ar_o.id", 64'(last_ar.id), 64'(AXI_ID));
    end
    else
      check_true(latency == 1, $sformatf("row %0d: hit answered after %0d cycles",
                                         cur_row, latency));
  endtask

  task automatic apply_maintenance(input row_t row);
    int   busy;
    int   expected_busy;
    logic stray;
    expected_busy    = (row.op == OP_FLUSH) ? 256 : 1;
    req_pc_i         = row.pc;
    req_flush_i      = (row.op == OP_FLUSH);
    req_invalidate_i = (row.op == OP_INVAL);
    while (!req_accept_o)
      @(negedge clk_i);
    @(negedge clk_i);
    req_flush_i      = 1'b0;
    req_invalidate_i = 1'b0;
    busy  = 0;
    stray = 1'b0;
    while (!req_accept_o)
    begin
      stray = stray | req_valid_o | ar_o.valid;
      busy++;
      @(negedge clk_i);
    end
    check_true(!stray, $sformatf("row %0d: fetch or bus activity while clearing", cur_row));
    check_true(busy == expected_busy,
               $sformatf("row %0d: cache busy for %0d cycles, expected %0d",
                         cur_row, busy, expected_busy));
  endtask

  //------------------------------------------------------------------------
  // Stimulus table
  //------------------------------------------------------------------------
  task automatic load_table();
    // op, pc, inject_error, expect_miss, expect_error
    rows[0]  = '{OP_READ,  32'h0000_0200, 1'b0, 1'b1, 1'b0};
    rows[1]  = '{OP_READ,  32'h0000_0208, 1'b0, 1'b0, 1'b0};
    rows[2]  = '{OP_READ,  32'h0000_021C, 1'b0, 1'b0, 1'b0};
    // Lines A, B and C share set 0x82
    rows[3]  = '{OP_READ,  32'h0000_1040, 1'b0, 1'b1, 1'b0};
    rows[4]  = '{OP_READ,  32'h0000_3040, 1'b0, 1'b1, 1'b0};
    rows[5]  = '{OP_READ,  32'h0000_1048, 1'b0, 1'b0, 1'b0};
    rows[6]  = '{OP_READ,  32'h0000_3058, 1'b0, 1'b0, 1'b0};
    // C evicts A
    rows[7]  = '{OP_READ,  32'h0000_5040, 1'b0, 1'b1, 1'b0};
    rows[8]  = '{OP_READ,  32'h0000_3040, 1'b0, 1'b0, 1'b0};
    rows[9]  = '{OP_READ,  32'h0000_1040, 1'b0, 1'b1, 1'b0};
    rows[10] = '{OP_READ,  32'h0000_5050, 1'b0, 1'b0, 1'b0};
    // B returns and evicts C, so A and B both live in the set
    rows[11] = '{OP_READ,  32'h0000_3048, 1'b0, 1'b1, 1'b0};
    // Single-set invalidate leaves other sets intact
    rows[12] = '{OP_INVAL, 32'h0000_1040, 1'b0, 1'b0, 1'b0};
    rows[13] = '{OP_READ,  32'h0000_1040, 1'b0, 1'b1, 1'b0};
    rows[14] = '{OP_READ,  32'h0000_3040, 1'b0, 1'b1, 1'b0};
    rows[15] = '{OP_READ,  32'h0000_0210, 1'b0, 1'b0, 1'b0};
    // Full flush
    rows[16] = '{OP_FLUSH, 32'h0000_0000, 1'b0, 1'b0, 1'b0};
    rows[17] = '{OP_READ,  32'h0000_0200, 1'b0, 1'b1, 1'b0};
    rows[18] = '{OP_READ,  32'h0000_1040, 1'b0, 1'b1, 1'b0};
    rows[19] = '{OP_READ,  32'h0000_3040, 1'b0, 1'b1, 1'b0};
    // Read error followed by a clean hit
    rows[20] = '{OP_READ,  32'h0000_0800, 1'b1, 1'b1, 1'b1};
    rows[21] = '{OP_READ,  32'h0000_0818, 1'b0, 1'b0, 1'b0};
    // Top set with high tag bits
    rows[22] = '{OP_READ,  32'h8000_1FE0, 1'b0, 1'b1, 1'b0};
    rows[23] = '{OP_READ,  32'h8000_1FF8, 1'b0, 1'b0, 1'b0};
  endtask

  //------------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------------
  initial
  begin
    int   flush_cycles;
    logic stray;
    rst_i            = 1'b1;
    req_rd_i         = 1'b0;
    req_flush_i      = 1'b0;
    req_invalidate_i = 1'b0;
    req_pc_i         = '0;
    err_inject       = 1'b0;
    cur_row          = 0;
    load_table();
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    // Sweep after reset clears one set per cycle
    flush_cycles = 0;
    stray        = 1'b0;
    while (!req_accept_o)
    begin
      stray = stray | req_valid_o | ar_o.valid;
      flush_cycles++;
      @(negedge clk_i);
    end
    check_true(!stray, "fetch or bus activity during the reset flush");
    check_true(flush_cycles == 256,
               $sformatf("reset flush took %0d cycles, expected 256", flush_cycles));
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      cur_row = i;
      if (rows[i].op == OP_READ)
        apply_read(rows[i]);
      else
        apply_maintenance(rows[i]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Run limit
  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run exceeded %0d cycles at row %0d", TIMEOUT_CYCLES, cur_row);
      $display("test failed");
      $finish;
    end
  end

endmodule

// File: compile.f
icache_pkg.sv
icache_ram.sv
icache_way.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_icache -o tb_icache -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_icache > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  exit 0
fi
exit 1
